//--- Makefile
# Verilator simulation of the CP0 testbench
VERILATOR ?= verilator
TOP       ?= cp0Tb
LOG       ?= sim.log
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "No errors" $(LOG); then \
		echo "FAIL: run ended early, see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- logic/cp0Pkg.sv
package cp0Pkg;

    // Architectural widths
    typedef logic [31:0] word_t;    // Data or address word
    typedef logic [4:0]  regNum_t;  // CP0 register number (rd field)
    typedef logic [2:0]  regSel_t;  // CP0 select field
    typedef logic [4:0]  excCode_t; // Cause ExcCode
    typedef logic [7:0]  intVec_t;  // Interrupt lines, pending or mask
    typedef logic [4:0]  hwInt_t;   // External hardware interrupts

    // Implemented register numbers, all at select 0
    localparam regNum_t RegBadVAddr = 5'd8;
    localparam regNum_t RegCount    = 5'd9;
    localparam regNum_t RegCompare  = 5'd11;
    localparam regNum_t RegStatus   = 5'd12;
    localparam regNum_t RegCause    = 5'd13;
    localparam regNum_t RegEpc      = 5'd14;

    // Status bit positions
    localparam int StatusCu0Bit = 28;  // CP0 usable in user mode
    localparam int StatusBevBit = 22;  // Boot exception vectors
    localparam int StatusImLsb  = 8;   // Interrupt mask, 8 bits
    localparam int StatusUmBit  = 4;   // User mode
    localparam int StatusExlBit = 1;   // Exception level
    localparam int StatusIeBit  = 0;   // Global interrupt enable

    // Cause bit positions
    localparam int CauseBdBit   = 31;  // Exception in branch delay slot
    localparam int CauseIvBit   = 23;  // Special interrupt vector
    localparam int CauseIpLsb   = 8;   // Interrupt pending, 8 bits
    localparam int CauseCodeLsb = 2;   // ExcCode, 5 bits

    // Exception codes
    localparam excCode_t ExcInt  = 5'd0;
    localparam excCode_t ExcAdEL = 5'd4;
    localparam excCode_t ExcAdES = 5'd5;
    localparam excCode_t ExcSys  = 5'd8;
    localparam excCode_t ExcBp   = 5'd9;
    localparam excCode_t ExcRI   = 5'd10;
    localparam excCode_t ExcCpU  = 5'd11;
    localparam excCode_t ExcOv   = 5'd12;
    localparam excCode_t ExcTr   = 5'd13;

    // Exception vectors
    localparam word_t VecReset      = 32'hBFC00000;
    localparam word_t VecBaseBoot   = 32'hBFC00200;  // BEV set
    localparam word_t VecBaseNormal = 32'h80000000;  // BEV clear
    localparam logic [11:0] VecOffGeneral = 12'h180;
    localparam logic [11:0] VecOffSpecial = 12'h200;  // Interrupts with IV set

endpackage

//--- logic/cp0Registers.sv
`timescale 1ns/10ps

module cp0Registers (
    input  logic              clock,
    input  logic              reset,
    input  logic              mfc0,
    input  logic              mtc0,
    input  logic              idStall,
    input  cp0Pkg::regNum_t   regNum,
    input  cp0Pkg::regSel_t   regSel,
    input  cp0Pkg::word_t     writeData,
    input  logic              idExcStall,
    input  cp0Pkg::hwInt_t    hwInt,
    input  logic              ifReady,
    input  logic              idReady,
    input  logic              exReady,
    input  logic              memReady,
    input  logic              eretCommit,
    input  cp0Pkg::excCode_t  excCode,
    input  cp0Pkg::word_t     excEpc,
    input  cp0Pkg::word_t     excBadAddr,
    input  logic              excIsBd,
    input  logic              badAddrValid,
    output cp0Pkg::word_t     readData,
    output logic              kernelMode,
    output logic              cp0Usable,
    output logic              statusBev,
    output logic              statusIe,
    output logic              statusExl,
    output logic              causeIv,
    output cp0Pkg::intVec_t   pending,
    output cp0Pkg::word_t     epc
);

    // Status and Cause fields
    logic statusCu0, statusUm;
    cp0Pkg::intVec_t statusIm;
    logic causeBd;
    logic [1:0] swIp;              // Software interrupts, IP[1:0]
    cp0Pkg::hwInt_t hwIp;          // Registered hardware lines, IP[6:2]
    cp0Pkg::excCode_t causeCode;
    cp0Pkg::word_t badVAddr;
    cp0Pkg::word_t statusWord, causeWord;
    cp0Pkg::word_t count, compare;
    cp0Pkg::intVec_t causeIp;
    logic timerIrq;
    logic anyReady, permitted, writeOk, readOk;
    logic isBadVAddr, isCount, isCompare, isStatus, isCause, isEpc;

    assign anyReady   = ifReady | idReady | exReady | memReady;
    assign kernelMode = ~statusUm | statusExl;
    assign cp0Usable  = statusCu0;
    assign permitted  = kernelMode | statusCu0;

    // A write waits for stalls and loses to a taken exception
    assign writeOk = mtc0 & permitted & ~idStall & ~idExcStall & ~anyReady;
    assign readOk  = mfc0 & permitted;

    // Register decode, select 0 only
    assign isBadVAddr = (regSel == 3'd0) && (regNum == cp0Pkg::RegBadVAddr);
    assign isCount    = (regSel == 3'd0) && (regNum == cp0Pkg::RegCount);
    assign isCompare  = (regSel == 3'd0) && (regNum == cp0Pkg::RegCompare);
    assign isStatus   = (regSel == 3'd0) && (regNum == cp0Pkg::RegStatus);
    assign isCause    = (regSel == 3'd0) && (regNum == cp0Pkg::RegCause);
    assign isEpc      = (regSel == 3'd0) && (regNum == cp0Pkg::RegEpc);

    cp0Timer uTimer (
        .clock        (clock),
        .reset        (reset),
        .countWrite   (writeOk & isCount),
        .compareWrite (writeOk & isCompare),
        .countRead    (readOk & isCount & ~idStall),  // Read acknowledges the timer
        .writeData    (writeData),
        .count        (count),
        .compare      (compare),
        .timerIrq     (timerIrq)
    );

    // IP7 timer, IP6..2 hardware, IP1..0 software
    assign causeIp = {timerIrq, hwIp, swIp};
    assign pending = causeIp & statusIm;

    // Status and Cause control bits
    always_ff @(posedge clock) begin
        if (reset) begin
            statusCu0 <= 1'b0;
            statusBev <= 1'b1;     // Boot vectors out of reset
            statusIm  <= '0;
            statusUm  <= 1'b0;     // Kernel mode
            statusExl <= 1'b0;
            statusIe  <= 1'b0;
            causeBd   <= 1'b0;
            causeIv   <= 1'b0;
            swIp      <= '0;
            causeCode <= '0;
            hwIp      <= '0;
        end else begin
            hwIp <= hwInt;         // One clock to reach IP
            if (anyReady) begin
                statusExl <= 1'b1;
                causeCode <= excCode;
                if (!statusExl)
                    causeBd <= excIsBd;  // Nested exception keeps first context
            end else begin
                if (writeOk && isStatus) begin
                    statusCu0 <= writeData[cp0Pkg::StatusCu0Bit];
                    statusBev <= writeData[cp0Pkg::StatusBevBit];
                    statusIm  <= writeData[cp0Pkg::StatusImLsb +: 8];
                    statusUm  <= writeData[cp0Pkg::StatusUmBit];
                    statusExl <= writeData[cp0Pkg::StatusExlBit];
                    statusIe  <= writeData[cp0Pkg::StatusIeBit];
                end else if (eretCommit) begin
                    statusExl <= 1'b0;   // Return from exception
                end
                if (writeOk && isCause) begin
                    causeIv <= writeData[cp0Pkg::CauseIvBit];
                    swIp    <= writeData[cp0Pkg::CauseIpLsb +: 2];
                end
            end
        end
    end

    // EPC and BadVAddr carry data only
    always_ff @(posedge clock) begin
        if (anyReady && !statusExl)
            epc <= excEpc;
        else if (writeOk && isEpc)
            epc <= writeData;
        if (anyReady && badAddrValid)
            badVAddr <= excBadAddr;
    end

    // Register images for mfc0
    always_comb begin
        statusWord = '0;
        statusWord[cp0Pkg::StatusCu0Bit]     = statusCu0;
        statusWord[cp0Pkg::StatusBevBit]     = statusBev;
        statusWord[cp0Pkg::StatusImLsb +: 8] = statusIm;
        statusWord[cp0Pkg::StatusUmBit]      = statusUm;
        statusWord[cp0Pkg::StatusExlBit]     = statusExl;
        statusWord[cp0Pkg::StatusIeBit]      = statusIe;
        causeWord = '0;
        causeWord[cp0Pkg::CauseBdBit]         = causeBd;
        causeWord[cp0Pkg::CauseIvBit]         = causeIv;
        causeWord[cp0Pkg::CauseIpLsb +: 8]    = causeIp;
        causeWord[cp0Pkg::CauseCodeLsb +: 5]  = causeCode;
    end

    // Read mux, zero for denied or unimplemented
    always_comb begin
        readData = '0;
        if (readOk) begin
            if (isBadVAddr)     readData = badVAddr;
            else if (isCount)   readData = count;
            else if (isCompare) readData = compare;
            else if (isStatus)  readData = statusWord;
            else if (isCause)   readData = causeWord;
            else if (isEpc)     readData = epc;
        end
    end

    // Every taken exception raises the exception level
    assert property (@(posedge clock) disable iff (reset)
        (ifReady | idReady | exReady | memReady) |=> statusExl);

endmodule

//--- logic/cp0Timer.sv
`timescale 1ns/10ps

module cp0Timer (
    input  logic          clock,
    input  logic          reset,
    input  logic          countWrite,
    input  logic          compareWrite,
    input  logic          countRead,
    input  cp0Pkg::word_t writeData,
    output cp0Pkg::word_t count,
    output cp0Pkg::word_t compare,
    output logic          timerIrq
);

    logic match;

    assign match = (count == compare);

    always_ff @(posedge clock) begin
        if (reset) begin
            count    <= '0;
            compare  <= '0;
            timerIrq <= 1'b0;
        end else begin
            // Free running, wraps to zero on a match
            if (countWrite)
                count <= writeData;
            else if (match)
                count <= '0;
            else
                count <= count + 32'd1;
            if (compareWrite)
                compare <= writeData;
            // Sticky until software reads Count
            if (countRead)
                timerIrq <= 1'b0;
            else if (match)
                timerIrq <= 1'b1;
        end
    end

endmodule

//--- logic/cp0Top.sv
`timescale 1ns/10ps

module cp0Top (
    input  logic             clock,
    input  logic             reset,
    input  logic             mfc0,
    input  logic             mtc0,
    input  logic             eret,
    input  logic             ifStall,
    input  logic             idStall,
    input  logic             idIsFlushed,
    input  cp0Pkg::regNum_t  regNum,
    input  cp0Pkg::regSel_t  regSel,
    input  cp0Pkg::word_t    writeData,
    input  logic             excAdIf,
    input  logic             excAdEl,
    input  logic             excAdEs,
    input  logic             excOv,
    input  logic             excTr,
    input  logic             excSys,
    input  logic             excBp,
    input  logic             excRi,
    input  cp0Pkg::word_t    idRestartPc,
    input  cp0Pkg::word_t    exRestartPc,
    input  cp0Pkg::word_t    memRestartPc,
    input  cp0Pkg::word_t    ifBadAddr,
    input  cp0Pkg::word_t    memBadAddr,
    input  logic             ifIsBd,
    input  logic             idIsBd,
    input  logic             exIsBd,
    input  logic             memIsBd,
    input  logic             idCanErr,
    input  logic             exCanErr,
    input  logic             memCanErr,
    input  cp0Pkg::hwInt_t   hwInt,
    output cp0Pkg::word_t    readData,
    output logic             kernelMode,
    output logic             ifExcStall,
    output logic             idExcStall,
    output logic             exExcStall,
    output logic             memExcStall,
    output logic             ifExcFlush,
    output logic             idExcFlush,
    output logic             exExcFlush,
    output logic             memExcFlush,
    output logic             excPcSel,
    output cp0Pkg::word_t    excPc
);

    logic ifReady, idReady, exReady, memReady, eretCommit;
    logic excIsBd, badAddrValid;
    cp0Pkg::word_t excEpc, excBadAddr, epc;
    cp0Pkg::excCode_t excCode;
    logic cp0Usable, statusBev, statusIe, statusExl, causeIv;
    cp0Pkg::intVec_t pending;

    exceptionArbiter uArbiter (
        .clock, .reset,
        .excAdIf, .excAdEl, .excAdEs, .excOv, .excTr, .excSys, .excBp, .excRi,
        .mfc0, .mtc0, .eret, .ifStall, .idStall, .idIsFlushed,
        .idRestartPc, .exRestartPc, .memRestartPc,
        .ifIsBd, .idIsBd, .exIsBd, .memIsBd,
        .ifBadAddr, .memBadAddr,
        .idCanErr, .exCanErr, .memCanErr,
        .kernelMode, .cp0Usable, .statusBev, .statusIe, .statusExl, .causeIv,
        .pending, .epc,
        .ifExcStall, .idExcStall, .exExcStall, .memExcStall,
        .ifExcFlush, .idExcFlush, .exExcFlush, .memExcFlush,
        .ifReady, .idReady, .exReady, .memReady, .eretCommit,
        .excPcSel, .excPc, .excEpc, .excBadAddr, .excCode, .excIsBd, .badAddrValid
    );

    cp0Registers uRegisters (
        .clock, .reset, .mfc0, .mtc0, .idStall,
        .regNum, .regSel, .writeData,
        .idExcStall, .hwInt,
        .ifReady, .idReady, .exReady, .memReady, .eretCommit,
        .excCode, .excEpc, .excBadAddr, .excIsBd, .badAddrValid,
        .readData, .kernelMode, .cp0Usable,
        .statusBev, .statusIe, .statusExl, .causeIv, .pending, .epc
    );

endmodule

//--- logic/exceptionArbiter.sv
`timescale 1ns/10ps

module exceptionArbiter (
    input  logic              clock,
    input  logic              reset,
    input  logic              excAdIf,
    input  logic              excAdEl,
    input  logic              excAdEs,
    input  logic              excOv,
    input  logic              excTr,
    input  logic              excSys,
    input  logic              excBp,
    input  logic              excRi,
    input  logic              mfc0,
    input  logic              mtc0,
    input  logic              eret,
    input  logic              ifStall,
    input  logic              idStall,
    input  logic              idIsFlushed,
    input  cp0Pkg::word_t     idRestartPc,
    input  cp0Pkg::word_t     exRestartPc,
    input  cp0Pkg::word_t     memRestartPc,
    input  logic              ifIsBd,
    input  logic              idIsBd,
    input  logic              exIsBd,
    input  logic              memIsBd,
    input  cp0Pkg::word_t     ifBadAddr,
    input  cp0Pkg::word_t     memBadAddr,
    input  logic              idCanErr,
    input  logic              exCanErr,
    input  logic              memCanErr,
    input  logic              kernelMode,
    input  logic              cp0Usable,
    input  logic              statusBev,
    input  logic              statusIe,
    input  logic              statusExl,
    input  logic              causeIv,
    input  cp0Pkg::intVec_t   pending,
    input  cp0Pkg::word_t     epc,
    output logic              ifExcStall,
    output logic              idExcStall,
    output logic              exExcStall,
    output logic              memExcStall,
    output logic              ifExcFlush,
    output logic              idExcFlush,
    output logic              exExcFlush,
    output logic              memExcFlush,
    output logic              ifReady,
    output logic              idReady,
    output logic              exReady,
    output logic              memReady,
    output logic              eretCommit,
    output logic              excPcSel,
    output cp0Pkg::word_t     excPc,
    output cp0Pkg::word_t     excEpc,
    output cp0Pkg::word_t     excBadAddr,
    output cp0Pkg::excCode_t  excCode,
    output logic              excIsBd,
    output logic              badAddrValid
);

    logic excCpU, excInt;
    logic memDetect, exDetect, idDetect, ifDetect;
    logic memHold, exHold, idHold, ifHold;
    logic generalExc;
    logic resetDelayed;        // Drives the IF flush just after reset
    cp0Pkg::word_t vecBase;
    logic [11:0] vecOff;

    // CP0 access from user mode without CU0
    assign excCpU = (mfc0 | mtc0 | eret) & ~(cp0Usable | kernelMode);
    assign excInt = (|pending) & statusIe & ~statusExl & ~idIsFlushed;

    // Exceptions grouped by the stage that raises them
    assign memDetect = excAdEl | excAdEs | excTr;
    assign exDetect  = excOv;
    assign idDetect  = excSys | excBp | excRi | excCpU | excInt;
    assign ifDetect  = excAdIf;

    // Hold while a later stage might still fault; interrupts also hold IF
    assign memHold = ifStall;
    assign exHold  = ifStall | memCanErr;
    assign idHold  = ifStall | memCanErr | exCanErr;
    assign ifHold  = ifStall | memCanErr | exCanErr | idCanErr | excInt;

    // No stall when a later stage is already faulting, that stage wins
    assign memExcStall = memDetect & memHold;
    assign exExcStall  = exDetect & exHold & ~memDetect;
    assign idExcStall  = (idDetect | eret | mtc0) & idHold & ~(exDetect | memDetect);
    assign ifExcStall  = ifDetect & ifHold & ~(idDetect | exDetect | memDetect);

    // Ready signals, front-most stage only
    assign memReady = memDetect & ~memHold & ~idStall;
    assign exReady  = exDetect & ~exHold & ~idStall & ~memDetect;
    assign idReady  = idDetect & ~idHold & ~idStall & ~(exDetect | memDetect);
    assign ifReady  = ifDetect & ~ifHold & ~idStall & ~(idDetect | exDetect | memDetect);

    assign eretCommit = eret & ~idStall;

    // A faulting stage flushes itself and everything behind it
    assign memExcFlush = memDetect;
    assign exExcFlush  = memDetect | exDetect;
    assign idExcFlush  = memDetect | exDetect | idDetect;
    assign ifExcFlush  = memDetect | exDetect | idDetect | ifDetect | eretCommit | resetDelayed;

    always_ff @(posedge clock) begin
        resetDelayed <= reset;
    end

    // Cause code, ordered by stage then by architectural priority
    always_comb begin
        if (excAdEl)     excCode = cp0Pkg::ExcAdEL;
        else if (excAdEs) excCode = cp0Pkg::ExcAdES;
        else if (excTr)  excCode = cp0Pkg::ExcTr;
        else if (excOv)  excCode = cp0Pkg::ExcOv;
        else if (excSys) excCode = cp0Pkg::ExcSys;
        else if (excBp)  excCode = cp0Pkg::ExcBp;
        else if (excRi)  excCode = cp0Pkg::ExcRI;
        else if (excCpU) excCode = cp0Pkg::ExcCpU;
        else if (excAdIf) excCode = cp0Pkg::ExcAdEL;  // Fetch fault reports as AdEL
        else             excCode = cp0Pkg::ExcInt;
    end

    // Restart context of the stage being taken
    always_comb begin
        if (memReady) begin
            excEpc  = memRestartPc;
            excIsBd = memIsBd;
        end else if (exReady) begin
            excEpc  = exRestartPc;
            excIsBd = exIsBd;
        end else if (idReady) begin
            excEpc  = idRestartPc;
            excIsBd = idIsBd;
        end else begin
            excEpc  = ifBadAddr;       // IF fault restarts at the bad fetch address
            excIsBd = ifIsBd;
        end
    end

    assign excBadAddr   = memReady ? memBadAddr : ifBadAddr;
    assign badAddrValid = memReady | ifReady;

    // Vector selection
    assign generalExc = memDetect | exDetect | ifDetect | excSys | excBp | excRi | excCpU;
    assign vecBase    = statusBev ? cp0Pkg::VecBaseBoot : cp0Pkg::VecBaseNormal;
    assign vecOff     = (excInt & causeIv & ~generalExc) ? cp0Pkg::VecOffSpecial
                                                         : cp0Pkg::VecOffGeneral;

    always_comb begin
        if (reset)           excPc = cp0Pkg::VecReset;
        else if (eretCommit) excPc = epc;
        else                 excPc = vecBase + {20'd0, vecOff};
    end

    assign excPcSel = reset | eretCommit | memReady | exReady | idReady | ifReady;

    // At most one stage is taken per cycle
    assert property (@(posedge clock) disable iff (reset)
        $onehot0({ifReady, idReady, exReady, memReady}));

endmodule

//--- sim/cp0Tests.svh
task automatic applyReset();
    cp0Pkg::word_t got;
    int startFails;
    startFails = failCount;
    repeat (8) @(posedge clock);
    #1 compareBit("excPcSel in reset", excPcSel, 1'b1);
    compareWord("excPc in reset", excPc, cp0Pkg::VecReset);
    @(negedge clock);
    reset = 1'b0;
    #1 compareBit("ifExcFlush after reset", ifExcFlush, 1'b1);
    @(negedge clock);
    #1 compareBit("excPcSel idle", excPcSel, 1'b0);
    compareBit("stall idle", ifExcStall | idExcStall | exExcStall | memExcStall, 1'b0);
    compareBit("flush idle", ifExcFlush | idExcFlush | exExcFlush | memExcFlush, 1'b0);
    compareBit("kernelMode", kernelMode, 1'b1);
    @(negedge clock);
    readReg(cp0Pkg::RegStatus, got);
    compareBit("Status BEV", got[cp0Pkg::StatusBevBit], 1'b1);
    reportTest("reset", startFails);
endtask

task automatic testRegisterAccess();
    cp0Pkg::word_t epcVal, cmpVal, statVal, got;
    int startFails;
    startFails = failCount;
    epcVal  = $urandom();
    cmpVal  = $urandom() | 32'h8000_0000;          // Far ahead of Count
    statVal = $urandom() & ~(UmWord | IeWord);     // Stay in kernel, no interrupts
    writeReg(cp0Pkg::RegEpc, epcVal);
    writeReg(cp0Pkg::RegCompare, cmpVal);
    writeReg(cp0Pkg::RegStatus, statVal);
    readReg(cp0Pkg::RegEpc, got);
    compareWord("EPC", got, epcVal);
    readReg(cp0Pkg::RegCompare, got);
    compareWord("Compare", got, cmpVal);
    readReg(cp0Pkg::RegStatus, got);
    compareWord("Status", got, statVal & StatusKept);
    readReg(5'd15, got);                           // PRId not implemented
    compareWord("register 15", got, '0);
    writeReg(cp0Pkg::RegStatus, BevWord | UmWord);
    compareBit("kernelMode in user", kernelMode, 1'b0);
    idRestartPc = $urandom();
    mfc0 = 1'b1;
    regNum = cp0Pkg::RegEpc;
    #1 compareWord("readData denied", readData, '0);
    compareBit("idExcFlush on CpU", idExcFlush, 1'b1);
    @(negedge clock);
    mfc0 = 1'b0;
    readReg(cp0Pkg::RegCause, got);                // EXL set, kernel again
    compareCode("ExcCode CpU", causeCodeOf(got), cp0Pkg::ExcCpU);
    reportTest("register access", startFails);
endtask

task automatic testPriorityCommit();
    cp0Pkg::word_t memPc, badAddr, got;
    int startFails;
    startFails = failCount;
    writeReg(cp0Pkg::RegStatus, BevWord);          // EXL clear
    ifStall = 1'b1;                                // Fetch stalled, MEM waits
    excAdEs = 1'b1;
    #1 compareBit("memExcStall", memExcStall, 1'b1);
    compareBit("excPcSel while stalled", excPcSel, 1'b0);
    @(negedge clock);
    ifStall = 1'b0;
    excAdEs = 1'b0;
    memCanErr = 1'b1;                              // MEM may still fault, EX waits
    excOv = 1'b1;
    #1 compareBit("exExcStall", exExcStall, 1'b1);
    @(negedge clock);
    memCanErr = 1'b0;
    excOv = 1'b0;
    memPc = $urandom();
    badAddr = $urandom();
    memRestartPc = memPc;
    exRestartPc = $urandom();
    idRestartPc = $urandom();
    memBadAddr = badAddr;
    excAdEl = 1'b1;
    excOv = 1'b1;
    excSys = 1'b1;
    #1 compareBit("memExcFlush", memExcFlush, 1'b1);
    compareBit("exExcFlush", exExcFlush, 1'b1);
    compareBit("idExcFlush", idExcFlush, 1'b1);
    compareBit("excPcSel", excPcSel, 1'b1);
    compareWord("excPc", excPc, cp0Pkg::VecBaseBoot + {20'd0, cp0Pkg::VecOffGeneral});
    @(negedge clock);
    clearInputs();
    readReg(cp0Pkg::RegEpc, got);
    compareWord("EPC from MEM", got, memPc);
    readReg(cp0Pkg::RegBadVAddr, got);
    compareWord("BadVAddr", got, badAddr);
    readReg(cp0Pkg::RegCause, got);
    compareCode("ExcCode AdEL", causeCodeOf(got), cp0Pkg::ExcAdEL);
    reportTest("priority and commit", startFails);
endtask

task automatic testForwardStall();
    cp0Pkg::word_t oldEpc, idPc, got;
    int startFails;
    startFails = failCount;
    writeReg(cp0Pkg::RegStatus, BevWord);
    readReg(cp0Pkg::RegEpc, oldEpc);
    idPc = $urandom();
    idRestartPc = idPc;
    excSys = 1'b1;
    exCanErr = 1'b1;                               // EX may still fault
    #1 compareBit("idExcStall", idExcStall, 1'b1);
    compareBit("excPcSel held", excPcSel, 1'b0);
    @(negedge clock);
    mfc0 = 1'b1;
    regNum = cp0Pkg::RegEpc;
    #1 compareWord("EPC while held", readData, oldEpc);
    @(negedge clock);
    mfc0 = 1'b0;
    exCanErr = 1'b0;
    #1 compareBit("excPcSel taken", excPcSel, 1'b1);
    compareBit("idExcStall released", idExcStall, 1'b0);
    @(negedge clock);
    clearInputs();
    readReg(cp0Pkg::RegEpc, got);
    compareWord("EPC from ID", got, idPc);
    writeReg(cp0Pkg::RegStatus, BevWord);
    idStall = 1'b1;                                // Back-pressure, nothing commits
    excSys = 1'b1;
    idRestartPc = $urandom();
    #1 compareBit("excPcSel under idStall", excPcSel, 1'b0);
    compareBit("idExcFlush under idStall", idExcFlush, 1'b1);
    @(negedge clock);
    excSys = 1'b0;
    mtc0 = 1'b1;
    regNum = cp0Pkg::RegEpc;
    writeData = $urandom();
    @(negedge clock);
    clearInputs();
    readReg(cp0Pkg::RegEpc, got);
    compareWord("EPC after idStall", got, idPc);
    readReg(cp0Pkg::RegStatus, got);
    compareBit("EXL after idStall", got[cp0Pkg::StatusExlBit], 1'b0);
    reportTest("forward stall", startFails);
endtask

task automatic testEret();
    cp0Pkg::word_t firstPc, got;
    int startFails;
    startFails = failCount;
    writeReg(cp0Pkg::RegStatus, BevWord);
    firstPc = $urandom();
    idRestartPc = firstPc;
    excSys = 1'b1;
    @(negedge clock);
    idRestartPc = $urandom();                      // Nested, EXL already set
    @(negedge clock);
    clearInputs();
    readReg(cp0Pkg::RegEpc, got);
    compareWord("EPC kept on nesting", got, firstPc);
    eret = 1'b1;
    #1 compareBit("excPcSel on eret", excPcSel, 1'b1);
    compareBit("ifExcFlush on eret", ifExcFlush, 1'b1);
    compareWord("excPc on eret", excPc, firstPc);
    @(negedge clock);
    eret = 1'b0;
    readReg(cp0Pkg::RegStatus, got);
    compareBit("EXL after eret", got[cp0Pkg::StatusExlBit], 1'b0);
    compareBit("kernelMode with UM clear", kernelMode, 1'b1);
    writeReg(cp0Pkg::RegStatus, BevWord | UmWord | ExlWord);
    eret = 1'b1;
    @(negedge clock);
    eret = 1'b0;
    compareBit("kernelMode with UM set", kernelMode, 1'b0);
    mfc0 = 1'b1;                                   // CpU trap back into kernel
    regNum = cp0Pkg::RegStatus;
    @(negedge clock);
    mfc0 = 1'b0;
    compareBit("kernelMode after trap", kernelMode, 1'b1);
    writeReg(cp0Pkg::RegStatus, BevWord);
    reportTest("eret", startFails);
endtask

task automatic testInterrupts();
    cp0Pkg::word_t got, cmpVal;
    int startFails, waited;
    logic seen;
    startFails = failCount;
    writeReg(cp0Pkg::RegStatus, BevWord | Hw0Mask | IeWord);
    idRestartPc = $urandom();
    hwInt = 5'b00001;
    #1 compareBit("excPcSel before IP", excPcSel, 1'b0);
    @(negedge clock);
    #1 compareBit("excPcSel on interrupt", excPcSel, 1'b1);
    compareBit("idExcFlush on interrupt", idExcFlush, 1'b1);
    compareWord("excPc boot", excPc, cp0Pkg::VecBaseBoot + {20'd0, cp0Pkg::VecOffGeneral});
    @(negedge clock);
    hwInt = '0;
    readReg(cp0Pkg::RegCause, got);
    compareCode("ExcCode Int", causeCodeOf(got), cp0Pkg::ExcInt);
    writeReg(cp0Pkg::RegCause, 32'h1 << cp0Pkg::CauseIvBit);
    writeReg(cp0Pkg::RegStatus, Hw0Mask | IeWord);  // BEV clear
    hwInt = 5'b00001;
    @(negedge clock);
    #1 compareWord("excPc special", excPc,
                   cp0Pkg::VecBaseNormal + {20'd0, cp0Pkg::VecOffSpecial});
    @(negedge clock);
    hwInt = '0;
    writeReg(cp0Pkg::RegStatus, BevWord);
    writeReg(cp0Pkg::RegCause, '0);
    cmpVal = 32'd6 + ($urandom() & 32'h7);
    writeReg(cp0Pkg::RegCount, '0);
    writeReg(cp0Pkg::RegCompare, cmpVal);
    readReg(cp0Pkg::RegCount, got);                // Drop the flag left from reset
    seen = 1'b0;
    waited = 0;
    while (!seen && waited < int'(cmpVal) + 2) begin
        readReg(cp0Pkg::RegCause, got);
        seen = got[cp0Pkg::CauseIpLsb + 7];
        waited++;
    end
    compareBit("Cause IP7 on match", seen, 1'b1);
    readReg(cp0Pkg::RegCount, got);
    readReg(cp0Pkg::RegCause, got);
    compareBit("Cause IP7 after Count read", got[cp0Pkg::CauseIpLsb + 7], 1'b0);
    reportTest("interrupts", startFails);
endtask

//--- sim/cp0Tb.sv
`timescale 1ns/10ps

module cp0Tb;

    localparam int ClockPeriod = 8;
    // Cycle budget per test, reset first
    localparam int BudgetCycles = 20 + 40 + 20 + 30 + 40 + 60;

    // Status images built from the architectural bit positions
    localparam cp0Pkg::word_t BevWord = 32'h1 << cp0Pkg::StatusBevBit;
    localparam cp0Pkg::word_t UmWord  = 32'h1 << cp0Pkg::StatusUmBit;
    localparam cp0Pkg::word_t ExlWord = 32'h1 << cp0Pkg::StatusExlBit;
    localparam cp0Pkg::word_t IeWord  = 32'h1 << cp0Pkg::StatusIeBit;
    localparam cp0Pkg::word_t Hw0Mask = 32'h4 << cp0Pkg::StatusImLsb;  // IM2 pairs with hwInt[0]
    localparam cp0Pkg::word_t StatusKept = (32'h1 << cp0Pkg::StatusCu0Bit) | BevWord
        | (32'hFF << cp0Pkg::StatusImLsb) | UmWord | ExlWord | IeWord;

    logic clock, reset;
    logic mfc0, mtc0, eret, ifStall, idStall, idIsFlushed;
    cp0Pkg::regNum_t regNum;
    cp0Pkg::regSel_t regSel;
    cp0Pkg::word_t writeData;
    logic excAdIf, excAdEl, excAdEs, excOv, excTr, excSys, excBp, excRi;
    cp0Pkg::word_t idRestartPc, exRestartPc, memRestartPc, ifBadAddr, memBadAddr;
    logic ifIsBd, idIsBd, exIsBd, memIsBd, idCanErr, exCanErr, memCanErr;
    cp0Pkg::hwInt_t hwInt;
    cp0Pkg::word_t readData, excPc;
    logic kernelMode, excPcSel;
    logic ifExcStall, idExcStall, exExcStall, memExcStall;
    logic ifExcFlush, idExcFlush, exExcFlush, memExcFlush;
    int passCount = 0;
    int failCount = 0;

    cp0Top u_dut (.*);

    initial clock = 1'b0;
    always #(ClockPeriod / 2) clock = ~clock;

    // Ends a hung run
    initial begin
        #(BudgetCycles * ClockPeriod + 400);
        $display("Watchdog expired, test sequence did not finish in %0d cycles", BudgetCycles);
        $display("Errors found");
        $finish;
    end

    task automatic compareWord(input string name, input cp0Pkg::word_t got,
                               input cp0Pkg::word_t exp);
        if (got === exp) begin
            passCount++;
        end else begin
            failCount++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        if (got === exp) begin
            passCount++;
        end else begin
            failCount++;
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compareCode(input string name, input cp0Pkg::excCode_t got,
                               input cp0Pkg::excCode_t exp);
        if (got === exp) begin
            passCount++;
        end else begin
            failCount++;
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic cp0Pkg::excCode_t causeCodeOf(input cp0Pkg::word_t cause);
        return cause[cp0Pkg::CauseCodeLsb +: 5];
    endfunction

    task automatic reportTest(input string name, input int startFails);
        $display("%s finished with %0d failing checks", name, failCount - startFails);
    endtask

    // Pipeline idle, PCs untouched
    task automatic clearInputs();
        {mfc0, mtc0, eret, ifStall, idStall, idIsFlushed} = '0;
        {excAdIf, excAdEl, excAdEs, excOv, excTr, excSys, excBp, excRi} = '0;
        {ifIsBd, idIsBd, exIsBd, memIsBd, idCanErr, exCanErr, memCanErr} = '0;
        regNum = '0;
        regSel = '0;
        writeData = '0;
        hwInt = '0;
    endtask

    // Called on a falling edge, returns on the next one
    task automatic writeReg(input cp0Pkg::regNum_t num, input cp0Pkg::word_t data);
        mtc0 = 1'b1;
        regNum = num;
        regSel = '0;
        writeData = data;
        @(negedge clock);
        mtc0 = 1'b0;
    endtask

    task automatic readReg(input cp0Pkg::regNum_t num, output cp0Pkg::word_t data);
        mfc0 = 1'b1;
        regNum = num;
        regSel = '0;
        #1 data = readData;     // Read mux is combinational
        @(negedge clock);
        mfc0 = 1'b0;
    endtask

    `include "cp0Tests.svh"

    initial begin
        void'($urandom(32'h25a3));  // One seed for the whole run
        clearInputs();
        {idRestartPc, exRestartPc, memRestartPc, ifBadAddr, memBadAddr} = '0;
        reset = 1'b1;
        applyReset();
        testRegisterAccess();
        testPriorityCommit();
        testForwardStall();
        testEret();
        testInterrupts();
        $display("Checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+sim
logic/cp0Pkg.sv
logic/cp0Timer.sv
logic/cp0Registers.sv
logic/exceptionArbiter.sv
logic/cp0Top.sv
sim/cp0Tb.sv
